// File: vlog.f
track_pkg.sv
frame_analyzer.sv
steer_regs.sv
motor_ctrl.sv
step_gen.sv
tracker_top.sv
tracker_asserts.sv
tracker_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tracker testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tracker_tb -f vlog.f -o tracker_sim
./obj_dir/tracker_sim

// File: tracker_tb.sv
/*
  tracker testbench
  drives camera frames and register writes into the tracker top level,
  checks wheel commands against a reference model and measures step rates
*/
`default_nettype none

module tracker_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int col_bits  = 6;   // 64 columns, 8 per zone
  localparam int nb_cnt    = 2;
  localparam int acc_bits  = 12;
  localparam int lost_lim  = (1 << nb_cnt) - 1;  // empty frames until lost
  localparam int frame_cyc = 64 + 4;             // pixels, eof, idle gap
  localparam int step_win  = 2000;               // cycles per step rate window
  localparam int n_frames  = 47;
  localparam int n_windows = 3;
  localparam int timeout_ns = (n_frames * frame_cyc + n_windows * step_win) * 4 * 2;

  logic                  rst = 1'b0;  // clock
  logic                  clk;         // reset, active high
  track_pkg::cam_pix_t   pix;
  logic                  wr;
  logic [3:0]            addr;
  logic [15:0]           wdata;
  track_pkg::motor_cmd_t cmd;
  logic                  step_left, dir_left, step_rght, dir_rght;

  integer                seed;
  track_pkg::steer_cfg_t cfg_m;    // register block model
  logic [7:0]            zones_m;  // controller model, last non-empty frame
  logic [2:0]            prox_m;
  int                    empty_m;  // empty frames in a row
  track_pkg::motor_cmd_t exp_q[$];
  int                    n_step_left = 0;
  int                    n_step_rght = 0;

  tracker_top #(.col_bits(col_bits), .nb_cnt(nb_cnt), .acc_bits(acc_bits)) dut_i (
    .rst(rst), .clk(clk), .pix(pix), .wr(wr), .addr(addr), .wdata(wdata), .cmd(cmd),
    .step_left(step_left), .dir_left(dir_left), .step_rght(step_rght), .dir_rght(dir_rght)
  );

  always #2 rst = ~rst;  // 4 ns period

  always @(negedge rst) begin
    if (step_left === 1'b1) n_step_left = n_step_left + 1;
    if (step_rght === 1'b1) n_step_rght = n_step_rght + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_cmd(input string name, input track_pkg::motor_cmd_t got,
                           input track_pkg::motor_cmd_t want);
    if (got !== want) begin
      abort_run($sformatf("error at %0t: %s got left %0d rght %0d, expected left %0d rght %0d",
                          $time, name, got.left, got.rght, want.left, want.rght));
    end
  endtask

  task automatic check_steps(input string name, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
      abort_run($sformatf("error at %0t: %s got %0d, expected %0d to %0d",
                          $time, name, got, lo, hi));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("error at %0t: %s got %b, expected %b", $time, name, got, want));
    end
  endtask

  // wheel speeds from zones, proximity and the lost flag
  function automatic track_pkg::motor_cmd_t expected_cmd(input logic [7:0] zones,
      input logic [2:0] prox, input logic lost, input track_pkg::steer_cfg_t cfg);
    track_pkg::motor_cmd_t   r;
    logic signed [15:0]      v;
    int                      mag;
    logic                    found;
    r = '0;
    found = 1'b0;
    mag = int'(prox[1:0]);
    if (cfg.en && !lost) begin
      if (zones[3] && zones[4]) begin  // centered
        if (mag == 0) v = '0;
        else v = cfg.vel[mag];
        if (prox[2]) v = -v;           // too close, back off
        r.left = v;
        r.rght = v;
      end else begin
        for (int k = 0; k < 4; k++) begin  // left half, right wheel turns
          if (!found && zones[3 - k]) begin
            r.rght = cfg.vel[k];
            found = 1'b1;
          end
        end
        for (int k = 0; k < 4; k++) begin  // right half, left wheel
          if (!found && zones[4 + k]) begin
            r.left = cfg.vel[k];
            found = 1'b1;
          end
        end
      end
    end
    return r;
  endfunction

  // zone mask and proximity of one frame of object pixels
  function automatic track_pkg::frame_meas_t meas_of(input logic [63:0] mask,
                                                     input track_pkg::steer_cfg_t cfg);
    track_pkg::frame_meas_t m;
    int                     n;
    int                     band;
    m = '0;
    n = $countones(mask);
    band = 0;
    for (int c = 0; c < 64; c++) begin
      if (mask[c]) m.zones[c / 8] = 1'b1;
    end
    for (int k = 0; k < 6; k++) begin
      if (n >= int'(cfg.thr[k])) band = k + 1;
    end
    case (band)
      0: m.prox = 3'b011;
      1: m.prox = 3'b010;
      2: m.prox = 3'b001;
      3: m.prox = 3'b000;
      4: m.prox = 3'b101;
      5: m.prox = 3'b110;
      default: m.prox = 3'b111;
    endcase
    return m;
  endfunction

  // n object pixels, at least one in each req zone, all inside allow zones
  function automatic logic [63:0] make_mask(input logic [7:0] req, input logic [7:0] allow,
                                            input int n);
    logic [63:0] m;
    int          c;
    int          limit;
    m = '0;
    limit = 8 * $countones(allow);
    for (int z = 0; z < 8; z++) begin
      if (req[z]) begin
        c = z * 8 + int'($unsigned($random(seed)) % 8);
        m[c] = 1'b1;
      end
    end
    while ($countones(m) < n && $countones(m) < limit) begin
      c = int'($unsigned($random(seed)) % 64);
      if (allow[c / 8]) m[c] = 1'b1;
    end
    return m;
  endfunction

  task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
    int k;
    k = int'(a);
    @(posedge rst);
    wr <= 1'b1;
    addr <= a;
    wdata <= d;
    @(posedge rst);
    wr <= 1'b0;
    if (k == 0) cfg_m.en = d[0];
    else if (k <= 4) cfg_m.vel[k - 1] = d;
    else if (k <= 10) cfg_m.thr[k - 5] = d;
  endtask

  // one frame, one pixel per column, then eof and a 3 cycle gap
  task automatic send_frame(input logic [63:0] mask);
    track_pkg::frame_meas_t m;
    track_pkg::cam_pix_t    p;
    m = meas_of(mask, cfg_m);
    if (m.zones != '0) begin
      zones_m = m.zones;
      prox_m  = m.prox;
      empty_m = 0;
    end else if (empty_m < lost_lim) begin
      empty_m = empty_m + 1;
    end
    exp_q.push_back(expected_cmd(zones_m, prox_m, empty_m == lost_lim, cfg_m));
    for (int c = 0; c < 64; c++) begin
      p = '0;
      p.vld = 1'b1;
      p.obj = mask[c];
      p.col = 10'(c);
      @(posedge rst);
      pix <= p;
    end
    p = '0;
    p.eof = 1'b1;
    @(posedge rst);
    pix <= p;
    repeat (3) begin
      @(posedge rst);
      pix <= '0;
    end
  endtask

  // step count and direction over a window at the current command
  task automatic measure_steps();
    track_pkg::motor_cmd_t c;
    int                    l0, r0, sl, sr, el, er;
    c = expected_cmd(zones_m, prox_m, empty_m == lost_lim, cfg_m);
    sl = int'(c.left);
    sr = int'(c.rght);
    if (sl < 0) sl = -sl;
    if (sr < 0) sr = -sr;
    el = (step_win * sl) / (1 << acc_bits);
    er = (step_win * sr) / (1 << acc_bits);
    @(posedge rst);
    l0 = n_step_left;
    r0 = n_step_rght;
    repeat (step_win) @(posedge rst);
    check_steps("step_left", n_step_left - l0, el - 1, el + 1);
    check_steps("step_rght", n_step_rght - r0, er - 1, er + 1);
    check_level("dir_left", dir_left, c.left[15]);
    check_level("dir_rght", dir_rght, c.rght[15]);
  endtask

  // cmd settles 3 edges after the eof cycle
  initial begin : compare_proc
    track_pkg::motor_cmd_t want;
    forever begin
      @(negedge rst);
      if (pix.eof === 1'b1) begin
        repeat (3) @(posedge rst);
        @(negedge rst);
        if (exp_q.size() == 0) begin
          abort_run("comparison found no expected command queued");
        end else begin
          want = exp_q.pop_front();
          check_cmd("cmd", cmd, want);
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    abort_run("timeout, the run did not finish in the expected time");
  end

  initial begin : stim_proc
    int         l0, r0;
    logic [7:0] z;
    int         bands[7];
    seed = 32'h4d1d;
    clk = 1'b1;
    pix = '0;
    wr = 1'b0;
    addr = '0;
    wdata = '0;
    cfg_m.en = 1'b0;
    cfg_m.vel = track_pkg::vel_dflt;
    cfg_m.thr = track_pkg::thr_dflt;
    zones_m = '0;
    prox_m = '0;
    empty_m = 0;
    bands = '{4, 12, 20, 28, 36, 44, 56};  // one count per proximity band
    repeat (2) @(posedge rst);
    clk <= 1'b0;

    // thresholds that a 64 pixel frame can cross
    write_reg(track_pkg::reg_thr0, 16'd8);
    write_reg(track_pkg::reg_thr1, 16'd16);
    write_reg(track_pkg::reg_thr2, 16'd24);
    write_reg(track_pkg::reg_thr3, 16'd32);
    write_reg(track_pkg::reg_thr4, 16'd40);
    write_reg(track_pkg::reg_thr5, 16'd48);

    // disabled, objects present but wheels stay still
    @(posedge rst);
    l0 = n_step_left;
    r0 = n_step_rght;
    send_frame(make_mask(8'h18, 8'hff, 30));
    send_frame(make_mask(8'h01, 8'h01, 5));
    send_frame(make_mask(8'h80, 8'h80, 5));
    send_frame(make_mask(8'h3c, 8'h3c, 20));
    check_steps("step_left", n_step_left - l0, 0, 0);
    check_steps("step_rght", n_step_rght - r0, 0, 0);

    // centered, every proximity band
    write_reg(track_pkg::reg_ctrl, 16'h0001);
    foreach (bands[i]) send_frame(make_mask(8'h18, 8'hff, bands[i]));
    write_reg(track_pkg::reg_vel2, 16'd150);
    send_frame(make_mask(8'h18, 8'hff, 12));  // band 010 now uses the new vel2

    // off center, single zones then mixed masks
    for (int i = 0; i < 8; i++) begin
      z = 8'(1 << i);
      send_frame(make_mask(z, z, 1 + int'($unsigned($random(seed)) % 8)));
    end
    send_frame(make_mask(8'h05, 8'h05, 4));
    send_frame(make_mask(8'ha0, 8'ha0, 4));
    send_frame(make_mask(8'h82, 8'h82, 6));
    send_frame(make_mask(8'h11, 8'h11, 6));
    send_frame(make_mask(8'h0c, 8'h0c, 3));
    send_frame(make_mask(8'h30, 8'h30, 3));
    send_frame(make_mask(8'h88, 8'h88, 9));
    repeat (12) begin
      z = 8'($random(seed));
      if (z == '0) z = 8'h40;
      send_frame(make_mask(z, z, $countones(z) + int'($unsigned($random(seed)) % 8)));
    end

    // lost target after three empty frames, then found again
    send_frame(make_mask(8'h04, 8'h04, 3));
    repeat (3) send_frame('0);
    send_frame(make_mask(8'h20, 8'h20, 2));

    // step rate forward, backward and on one wheel
    send_frame(make_mask(8'h18, 8'hff, 4));
    measure_steps();
    write_reg(track_pkg::reg_vel3, 16'd1000);
    send_frame(make_mask(8'h18, 8'hff, 56));
    measure_steps();
    send_frame(make_mask(8'h02, 8'h02, 2));
    measure_steps();

    repeat (2) @(posedge rst);
    if (exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("not every frame result was compared");
    end
  end

endmodule

`default_nettype wire

// File: tracker_asserts.sv
/*
  tracker assertions
  bound into the motor controller and both step generators,
  ctrl_side picks the checks that fit the target
*/
`default_nettype none

module tracker_asserts #(
  parameter bit ctrl_side = 1'b1  // 1 controller checks, 0 step generator check
) (
  input logic                               rst,  // clock
  input logic                               clk,  // reset
  input logic                               en,
  input logic                               new_meas,
  input track_pkg::motor_cmd_t              cmd,
  input logic signed [track_pkg::dps_w-1:0] dps,
  input logic                               step
);
  timeunit 1ns;
  timeprecision 1ps;

  if (ctrl_side) begin : ctrl_chk
    // cmd is computed from en of the cycle before
    cmd_off_chk: assert property (@(posedge rst) disable iff (clk)
      !$past(en) |-> cmd == '0)
      else $error("cmd left %0d rght %0d while disabled", cmd.left, cmd.rght);

    meas_pulse_chk: assert property (@(posedge rst) disable iff (clk)
      new_meas |=> !new_meas)
      else $error("new_meas high two cycles in a row");
  end else begin : step_chk
    // zero speed adds nothing to the phase accumulator
    step_idle_chk: assert property (@(posedge rst) disable iff (clk)
      $past(dps) == '0 |-> !step)
      else $error("step pulse at zero speed");
  end

endmodule

// inputs of the checks that a target does not use are tied off
bind motor_ctrl tracker_asserts #(.ctrl_side(1'b1)) ctrl_asserts_i (
  .rst(rst), .clk(clk), .en(cfg.en), .new_meas(new_meas), .cmd(cmd), .dps('0), .step(1'b0)
);

bind step_gen tracker_asserts #(.ctrl_side(1'b0)) step_asserts_i (
  .rst(rst), .clk(clk), .en(1'b1), .new_meas(1'b0), .cmd('0), .dps(dps), .step(step)
);

`default_nettype wire

// File: tracker_top.sv
/*
  tracker top level
  camera frame analyzer, configuration registers, motor controller
  and one step generator per wheel
*/
`default_nettype none

module tracker_top #(
  parameter int col_bits = 10,  // camera column bits
  parameter int nb_cnt   = 6,   // lost-target counter width
  parameter int acc_bits = 16   // step accumulator width
) (
  input  logic                  rst,    // clock
  input  logic                  clk,    // async reset, active high
  input  track_pkg::cam_pix_t   pix,
  input  logic                  wr,
  input  logic [3:0]            addr,
  input  logic [15:0]           wdata,
  output track_pkg::motor_cmd_t cmd,
  output logic                  step_left,
  output logic                  dir_left,
  output logic                  step_rght,
  output logic                  dir_rght
);

  track_pkg::steer_cfg_t  cfg;
  track_pkg::frame_meas_t meas;
  logic                   new_meas;

  frame_analyzer #(.col_bits(col_bits)) analyzer_i (
    .rst(rst), .clk(clk), .pix(pix), .cfg(cfg), .meas(meas), .new_meas(new_meas)
  );

  steer_regs regs_i (
    .rst(rst), .clk(clk), .wr(wr), .addr(addr), .wdata(wdata), .cfg(cfg)
  );

  motor_ctrl #(.nb_cnt(nb_cnt)) ctrl_i (
    .rst(rst), .clk(clk), .meas(meas), .new_meas(new_meas), .cfg(cfg), .cmd(cmd)
  );

  // left wheel
  step_gen #(.acc_bits(acc_bits)) step_left_i (
    .rst(rst), .clk(clk), .dps(cmd.left), .step(step_left), .dir(dir_left)
  );

  // right wheel
  step_gen #(.acc_bits(acc_bits)) step_rght_i (
    .rst(rst), .clk(clk), .dps(cmd.rght), .step(step_rght), .dir(dir_rght)
  );

endmodule

`default_nettype wire

// File: step_gen.sv
/*
  step generator
  phase accumulator driven by the absolute wheel speed,
  carry out gives a step pulse, sign gives the direction
*/
`default_nettype none

module step_gen #(
  parameter int acc_bits = 16  // phase accumulator width
) (
  input  logic                               rst,  // clock
  input  logic                               clk,  // async reset, active high
  input  logic signed [track_pkg::dps_w-1:0] dps,
  output logic                               step,
  output logic                               dir   // 1 backward
);

  // room for the carry even when the speed is wider than the accumulator
  localparam int sum_w = ((acc_bits > track_pkg::dps_w) ? acc_bits : track_pkg::dps_w) + 1;

  logic [track_pkg::dps_w-1:0] mag;  // |dps|, 16'h8000 reads as 32768
  logic [acc_bits-1:0]         acc;
  logic [sum_w-1:0]            sum;
  logic                        carry;

  assign mag   = dps[track_pkg::dps_w-1] ? -dps : dps;
  assign sum   = sum_w'(acc) + sum_w'(mag);
  assign carry = |sum[sum_w-1:acc_bits];  // at most one step per cycle

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      acc  <= '0;
      step <= 1'b0;
      dir  <= 1'b0;
    end else begin
      acc  <= sum[acc_bits-1:0];
      step <= carry;
      dir  <= dps[track_pkg::dps_w-1];
    end
  end

endmodule

`default_nettype wire

// File: motor_ctrl.sv
/*
  motor controller
  keeps the last valid zone mask and proximity, counts empty frames,
  and selects signed wheel speeds from the speed table
*/
`default_nettype none

module motor_ctrl #(
  parameter int nb_cnt = 6  // empty frames before the target is lost
) (
  input  logic                   rst,       // clock
  input  logic                   clk,       // async reset, active high
  input  track_pkg::frame_meas_t meas,
  input  logic                   new_meas,  // one-cycle strobe per frame
  input  track_pkg::steer_cfg_t  cfg,
  output track_pkg::motor_cmd_t  cmd
);

  logic [7:0]                     last_zones;  // last non-empty mask
  logic [2:0]                     last_prox;
  logic [nb_cnt-1:0]              cnt;         // empty frames in a row
  logic                           lost;
  logic                           tracking;
  logic signed [track_pkg::dps_w-1:0] mag;     // centered speed magnitude
  track_pkg::motor_cmd_t          cmd_nxt;

  assign tracking = |meas.zones;  // something in the frame
  assign lost     = &cnt;         // saturated counter

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      last_zones <= '0;
      last_prox  <= '0;
      cnt        <= '0;
    end else if (new_meas) begin
      if (tracking) begin
        last_zones <= meas.zones;
        last_prox  <= meas.prox;
        cnt        <= '0;
      end else if (!lost) begin
        cnt <= cnt + 1'b1;  // hold once all ones
      end
    end
  end

  // magnitude when centered, 0 means hold position
  always_comb begin
    case (last_prox[1:0])
      2'd1:    mag = cfg.vel[1];
      2'd2:    mag = cfg.vel[2];
      2'd3:    mag = cfg.vel[3];
      default: mag = '0;
    endcase
  end

  always_comb begin
    cmd_nxt = '0;
    if (cfg.en && !lost) begin
      if (last_zones[3] && last_zones[4]) begin
        // centered, backwards when too close
        cmd_nxt.left = last_prox[2] ? -mag : mag;
        cmd_nxt.rght = last_prox[2] ? -mag : mag;
      end else if (last_zones[3]) begin  // slightly left, turn with right wheel
        cmd_nxt.rght = cfg.vel[0];
      end else if (last_zones[2]) begin
        cmd_nxt.rght = cfg.vel[1];
      end else if (last_zones[1]) begin
        cmd_nxt.rght = cfg.vel[2];
      end else if (last_zones[0]) begin  // far left, fastest
        cmd_nxt.rght = cfg.vel[3];
      end else if (last_zones[4]) begin  // slightly right, left wheel
        cmd_nxt.left = cfg.vel[0];
      end else if (last_zones[5]) begin
        cmd_nxt.left = cfg.vel[1];
      end else if (last_zones[6]) begin
        cmd_nxt.left = cfg.vel[2];
      end else if (last_zones[7]) begin
        cmd_nxt.left = cfg.vel[3];
      end
    end
  end

  // registered command, one edge after the stored state
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cmd <= '0;
    end else begin
      cmd <= cmd_nxt;
    end
  end

endmodule

`default_nettype wire

// File: steer_regs.sv
/*
  steering configuration registers
  write-only enable, speed table and proximity thresholds,
  loaded with the package defaults on reset
*/
`default_nettype none

module steer_regs (
  input  logic                  rst,    // clock
  input  logic                  clk,    // async reset, active high
  input  logic                  wr,     // write strobe
  input  logic [3:0]            addr,
  input  logic [15:0]           wdata,
  output track_pkg::steer_cfg_t cfg
);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cfg.en  <= 1'b0;                  // motors off until software enables
      cfg.vel <= track_pkg::vel_dflt;
      cfg.thr <= track_pkg::thr_dflt;
    end else if (wr) begin
      case (addr)
        track_pkg::reg_ctrl: begin
          cfg.en <= wdata[0];           // other ctrl bits not stored
        end
        track_pkg::reg_vel0: cfg.vel[0] <= wdata;
        track_pkg::reg_vel1: cfg.vel[1] <= wdata;
        track_pkg::reg_vel2: cfg.vel[2] <= wdata;
        track_pkg::reg_vel3: cfg.vel[3] <= wdata;
        // thresholds taken as written, ordering is up to software
        track_pkg::reg_thr0: cfg.thr[0] <= wdata;
        track_pkg::reg_thr1: cfg.thr[1] <= wdata;
        track_pkg::reg_thr2: cfg.thr[2] <= wdata;
        track_pkg::reg_thr3: cfg.thr[3] <= wdata;
        track_pkg::reg_thr4: cfg.thr[4] <= wdata;
        track_pkg::reg_thr5: cfg.thr[5] <= wdata;
        default: begin
          // unmapped address, write dropped
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: frame_analyzer.sv
/*
  frame analyzer
  builds an 8-zone horizontal mask and an object pixel count over a frame,
  codes the count into a proximity value at end of frame
*/
`default_nettype none

module frame_analyzer #(
  parameter int col_bits = 10  // 3 to 10 significant column bits
) (
  input  logic                   rst,  // clock
  input  logic                   clk,  // async reset, active high
  input  track_pkg::cam_pix_t    pix,
  input  track_pkg::steer_cfg_t  cfg,
  output track_pkg::frame_meas_t meas,
  output logic                   new_meas
);

  logic [7:0]                  zone_acc;  // running mask of the frame
  logic [track_pkg::cnt_w-1:0] cnt_acc;   // object pixels so far
  logic [2:0]                  zone_idx;
  logic [2:0]                  prox_code;
  logic                        hit;

  // top three column bits select the eighth of the image
  assign zone_idx = pix.col[col_bits-1 -: 3];
  assign hit      = pix.vld & pix.obj;

  // count against the thresholds, few pixels means far away
  always_comb begin
    if (cnt_acc < cfg.thr[0]) begin
      prox_code = 3'b011;  // very far
    end else if (cnt_acc < cfg.thr[1]) begin
      prox_code = 3'b010;
    end else if (cnt_acc < cfg.thr[2]) begin
      prox_code = 3'b001;
    end else if (cnt_acc < cfg.thr[3]) begin
      prox_code = 3'b000;  // right distance, hold
    end else if (cnt_acc < cfg.thr[4]) begin
      prox_code = 3'b101;
    end else if (cnt_acc < cfg.thr[5]) begin
      prox_code = 3'b110;
    end else begin
      prox_code = 3'b111;  // much too close
    end
  end

  // accumulators, cleared by eof so the next frame can follow at once
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      zone_acc <= '0;
      cnt_acc  <= '0;
    end else if (pix.eof) begin
      zone_acc <= '0;
      cnt_acc  <= '0;
    end else if (hit) begin
      zone_acc[zone_idx] <= 1'b1;
      if (cnt_acc != '1) begin  // saturate
        cnt_acc <= cnt_acc + 1'b1;
      end
    end
  end

  // one-cycle strobe with the frame result
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      new_meas <= 1'b0;
    end else begin
      new_meas <= pix.eof;
    end
  end

  always_ff @(posedge rst) begin
    if (pix.eof) begin
      meas.zones <= zone_acc;
      meas.prox  <= prox_code;  // consumer only looks at it with new_meas
    end
  end

endmodule

`default_nettype wire

// File: track_pkg.sv
/*
  tracker shared definitions
  pixel event, frame result, configuration and wheel command structs,
  register map and the reset values of the configuration
*/
`default_nettype none

package track_pkg;

  localparam int col_w = 10;  // pixel column field
  localparam int dps_w = 16;  // wheel speed, signed deg/s
  localparam int cnt_w = 16;  // object pixels per frame

  // one camera pixel event per cycle
  typedef struct packed {
    logic             vld;  // pixel strobe
    logic             obj;  // pixel belongs to the object
    logic [col_w-1:0] col;  // column of the pixel
    logic             eof;  // pulse after the last pixel of a frame
  } cam_pix_t;

  // reduced frame result
  typedef struct packed {
    logic [7:0] zones;  // bit 0 is the leftmost eighth
    logic [2:0] prox;   // bit 2 too close, 1:0 magnitude
  } frame_meas_t;

  typedef struct packed {
    logic                       en;
    logic [3:0][dps_w-1:0]      vel;  // vel[0] .. vel[3]
    logic [5:0][cnt_w-1:0]      thr;  // thr[0] .. thr[5], ascending
  } steer_cfg_t;

  typedef struct packed {
    logic signed [dps_w-1:0] left;
    logic signed [dps_w-1:0] rght;
  } motor_cmd_t;

  // write address map
  localparam logic [3:0] reg_ctrl = 4'd0;
  localparam logic [3:0] reg_vel0 = 4'd1;
  localparam logic [3:0] reg_vel1 = 4'd2;
  localparam logic [3:0] reg_vel2 = 4'd3;
  localparam logic [3:0] reg_vel3 = 4'd4;
  localparam logic [3:0] reg_thr0 = 4'd5;
  localparam logic [3:0] reg_thr1 = 4'd6;
  localparam logic [3:0] reg_thr2 = 4'd7;
  localparam logic [3:0] reg_thr3 = 4'd8;
  localparam logic [3:0] reg_thr4 = 4'd9;
  localparam logic [3:0] reg_thr5 = 4'd10;

  // reset values, highest index first
  localparam logic [3:0][dps_w-1:0] vel_dflt = {16'd200, 16'd100, 16'd50, 16'd25};
  localparam logic [5:0][cnt_w-1:0] thr_dflt =
    {16'd300, 16'd200, 16'd120, 16'd80, 16'd40, 16'd20};

endpackage

`default_nettype wire
